/* Bender.yml */
package:
  name: core_trace

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/core_trace_pkg.sv
      - verilog/exe_event_capture.sv
      - verilog/stage_shadow.sv
      - verilog/retire_trace.sv
      - verilog/core_trace_top.sv

  - target: test
    include_dirs:
      - verilog
    files:
      - verification/trace_clk_gen.sv
      - verification/core_trace_assert.sv
      - verification/core_trace_tb.sv

/* core_trace.f */
+incdir+verilog
verilog/core_trace_pkg.sv
verilog/exe_event_capture.sv
verilog/stage_shadow.sv
verilog/retire_trace.sv
verilog/core_trace_top.sv
verification/trace_clk_gen.sv
verification/core_trace_assert.sv
verification/core_trace_tb.sv

/* verification/core_trace_assert.sv */
`timescale 1ns/1ns
`default_nettype none

module core_trace_assert
    import core_trace_pkg::*;
(
    input logic       clk,
    input logic       rst_n,
    input logic       trace_valid,
    input logic       inst_retired,
    input logic       bubble_wbk,
    input trace_cnt_t counts
);

    // sync reset, so trace_valid is clear one edge into reset
    a_no_valid_in_reset: assert property (
        @(posedge clk) !rst_n |=> !trace_valid
    ) else $error("trace_valid high during reset");

    // retiring a bubble slot leaves no record behind
    a_bubble_no_record: assert property (
        @(posedge clk) disable iff (!rst_n)
        (inst_retired && bubble_wbk) |=> !trace_valid
    ) else $error("trace record produced for a bubble slot");

    a_counts_monotonic: assert property (
        @(posedge clk) disable iff (!rst_n)
        counts.retired >= $past(counts.retired) &&
        counts.branches >= $past(counts.branches) &&
        counts.taken >= $past(counts.taken) &&
        counts.bp_hits >= $past(counts.bp_hits) &&
        counts.loads >= $past(counts.loads) &&
        counts.stores >= $past(counts.stores) &&
        counts.bubbles_seen >= $past(counts.bubbles_seen)
    ) else $error("event counter went backwards");

endmodule

`default_nettype wire

/* verification/core_trace_tb.sv */
`timescale 1ns/1ns
`include "core_trace_defines.svh"
`default_nettype none

module core_trace_tb
    import core_trace_pkg::*;
();

    localparam int STIM_CYCLES    = 1500;
    localparam int DRAIN_CYCLES   = 8;
    // covers the stimulus cycles plus reset, drain and margin
    localparam int TIMEOUT_CYCLES = 2000;

    typedef struct packed {
        trace_rec_t rec;
        trace_cnt_t cnt;
    } exp_item_t;

    logic                   clk;
    logic                   rst_n;
    stage_ctrl_t            ctrl_dec_exe;
    stage_ctrl_t            ctrl_exe_mem;
    stage_ctrl_t            ctrl_mem_wbk;
    logic [`INST_WIDTH-1:0] inst_dec;
    logic [`ARCH_WIDTH-1:0] pc_dec;
    branch_res_t            branch_resolution;
    logic                   bp_hit;
    dmem_req_t              dmem_req;
    logic                   inst_retired;
    logic                   trace_valid;
    trace_rec_t             trace;
    trace_cnt_t             counts;

    // reference pipeline with one slot per stage
    inst_rec_t   m_exe_inst, m_mem_inst, m_wbk_inst;
    exe_event_t  m_mem_ev, m_wbk_ev;
    logic        m_exe_bub, m_mem_bub, m_wbk_bub;
    // wbk holds an instruction not yet retired
    logic        m_wbk_fresh;
    // a retirement happens at the coming rising edge
    logic        retire_due;
    // trace_valid expected after the last rising edge
    logic        valid_due;
    trace_cnt_t  exp_cnt;
    exp_item_t   exp_q[$];
    int unsigned fail_cnt = 0;
    int unsigned cycle_cnt = 0;

    trace_clk_gen u_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    core_trace_top i_core_trace_top (
        .clk               (clk),
        .rst_n             (rst_n),
        .ctrl_dec_exe      (ctrl_dec_exe),
        .ctrl_exe_mem      (ctrl_exe_mem),
        .ctrl_mem_wbk      (ctrl_mem_wbk),
        .inst_dec          (inst_dec),
        .pc_dec            (pc_dec),
        .branch_resolution (branch_resolution),
        .bp_hit            (bp_hit),
        .dmem_req          (dmem_req),
        .inst_retired      (inst_retired),
        .trace_valid       (trace_valid),
        .trace             (trace),
        .counts            (counts)
    );

    bind core_trace_top core_trace_assert u_assert (
        .clk          (clk),
        .rst_n        (rst_n),
        .trace_valid  (trace_valid),
        .inst_retired (inst_retired),
        .bubble_wbk   (bubble_wbk),
        .counts       (counts)
    );

    // expected record for an instruction entering exe
    function automatic inst_rec_t ref_inst_rec(input logic [31:0] inst, input logic [31:0] pc);
        inst_rec_t r;
        r.inst  = inst;
        r.pc    = pc;
        r.flush = (inst == 32'h0);
        case (inst[6:0])
            7'h33:                      r.fmt = FMT_R;
            7'h13, 7'h03, 7'h67, 7'h73: r.fmt = FMT_I;
            7'h23:                      r.fmt = FMT_S;
            7'h63:                      r.fmt = FMT_B;
            7'h6f:                      r.fmt = FMT_J;
            7'h37, 7'h17:               r.fmt = FMT_U;
            default:                    r.fmt = FMT_NONE;
        endcase
        return r;
    endfunction

    // expected exe event from the exe instruction and that cycle's inputs
    function automatic exe_event_t ref_exe_event(input logic [31:0] inst, input branch_res_t res,
                                                 input logic hit, input dmem_req_t req);
        exe_event_t e;
        e.branch    = (inst[6:0] == 7'h63);
        e.taken     = e.branch && (res == B_T);
        e.bp_hit    = e.branch && hit;
        e.dmem_acc  = DMEM_NA;
        e.dmem_addr = req.valid ? req.addr : '0;
        if (req.valid && req.size != 2'b11) begin
            case (req.size)
                2'b00:   e.dmem_acc = req.store ? DMEM_SB : DMEM_LB;
                2'b01:   e.dmem_acc = req.store ? DMEM_SH : DMEM_LH;
                default: e.dmem_acc = req.store ? DMEM_SW : DMEM_LW;
            endcase
        end
        return e;
    endfunction

    // opcode mix with nop, zero word and two unknown opcodes
    function automatic logic [31:0] random_inst();
        logic [31:0] word;
        word = $urandom;
        case ($urandom_range(15, 0))
            0:       word[6:0] = 7'h33;
            1:       word[6:0] = 7'h13;
            2:       word[6:0] = 7'h03;
            3:       word[6:0] = 7'h23;
            4:       word[6:0] = 7'h6f;
            5:       word[6:0] = 7'h67;
            6:       word[6:0] = 7'h37;
            7:       word[6:0] = 7'h17;
            8:       word[6:0] = 7'h73;
            9:       word = `NOP;
            10:      word = '0;
            11:      word[6:0] = 7'h0f;
            12:      word[6:0] = 7'h7f;
            default: word[6:0] = 7'h63;
        endcase
        return word;
    endfunction

    function automatic stage_ctrl_t random_ctrl();
        stage_ctrl_t c;
        c.en     = ($urandom_range(7, 0) != 0);
        c.bubble = ($urandom_range(15, 0) == 0);
        return c;
    endfunction

    task automatic check_value(input logic [127:0] got, input logic [127:0] exp,
                               input string what);
        if (got !== exp) begin
            fail_cnt++;
            $display("FAIL at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
            $display("Checks failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // retire from wbk, advance the model and drive the DUT for one cycle
    task automatic step_cycle(input bit random_inputs);
        stage_ctrl_t c_de, c_em, c_mw;
        logic [31:0] inst_n, pc_n;
        branch_res_t res_n;
        logic        hit_n;
        logic        retire_n;
        dmem_req_t   req_n;
        exe_event_t  ev_exe;
        exp_item_t   item;
        if (random_inputs) begin
            c_de          = random_ctrl();
            c_em          = random_ctrl();
            c_mw          = random_ctrl();
            inst_n        = random_inst();
            pc_n          = $urandom & 32'hffff_fffc;
            res_n         = ($urandom_range(1, 0) == 1) ? B_T : B_NT;
            hit_n         = ($urandom_range(1, 0) == 1);
            req_n.valid   = ($urandom_range(1, 0) == 1);
            req_n.addr    = $urandom;
            req_n.store   = ($urandom_range(1, 0) == 1);
            req_n.size    = 2'($urandom_range(3, 0));
        end else begin
            // only bubbles enter exe while draining
            c_de   = '{en: 1'b1, bubble: 1'b1};
            c_em   = '{en: 1'b1, bubble: 1'b0};
            c_mw   = '{en: 1'b1, bubble: 1'b0};
            inst_n = `NOP;
            pc_n   = '0;
            res_n  = B_NT;
            hit_n  = 1'b0;
            req_n  = '0;
        end
        retire_n   = m_wbk_fresh;
        retire_due = m_wbk_fresh;
        // a stray retire strobe on a bubble slot now and then
        if (random_inputs && m_wbk_bub && $urandom_range(7, 0) == 0) begin
            retire_n = 1'b1;
        end
        if (m_wbk_fresh) begin
            exp_cnt.retired  = exp_cnt.retired + 1'b1;
            exp_cnt.branches = exp_cnt.branches + m_wbk_ev.branch;
            exp_cnt.taken    = exp_cnt.taken + m_wbk_ev.taken;
            exp_cnt.bp_hits  = exp_cnt.bp_hits + m_wbk_ev.bp_hit;
            if (m_wbk_ev.dmem_acc inside {DMEM_LB, DMEM_LH, DMEM_LW}) begin
                exp_cnt.loads = exp_cnt.loads + 1'b1;
            end
            if (m_wbk_ev.dmem_acc inside {DMEM_SB, DMEM_SH, DMEM_SW}) begin
                exp_cnt.stores = exp_cnt.stores + 1'b1;
            end
            item.rec.inst_rec = m_wbk_inst;
            item.rec.exe_ev   = m_wbk_ev;
            item.rec.bubble   = 1'b0;
            item.cnt          = exp_cnt;
            exp_q.push_back(item);
            m_wbk_fresh = 1'b0;
        end
        if (m_wbk_bub) begin
            exp_cnt.bubbles_seen = exp_cnt.bubbles_seen + 1'b1;
        end
        ev_exe = ref_exe_event(m_exe_inst.inst, res_n, hit_n, req_n);
        // later stages update first so they see the old values
        if (c_mw.en) begin
            m_wbk_inst  = c_mw.bubble ? '0 : m_mem_inst;
            m_wbk_ev    = c_mw.bubble ? '0 : m_mem_ev;
            m_wbk_bub   = c_mw.bubble ? 1'b1 : m_mem_bub;
            m_wbk_fresh = !m_wbk_bub;
        end
        if (c_em.en) begin
            m_mem_inst = c_em.bubble ? '0 : m_exe_inst;
            m_mem_ev   = c_em.bubble ? '0 : ev_exe;
            m_mem_bub  = c_em.bubble ? 1'b1 : m_exe_bub;
        end
        if (c_de.en) begin
            m_exe_inst = c_de.bubble ? '0 : ref_inst_rec(inst_n, pc_n);
            m_exe_bub  = c_de.bubble;
        end
        ctrl_dec_exe      = c_de;
        ctrl_exe_mem      = c_em;
        ctrl_mem_wbk      = c_mw;
        inst_dec          = inst_n;
        pc_dec            = pc_n;
        branch_resolution = res_n;
        bp_hit            = hit_n;
        dmem_req          = req_n;
        inst_retired      = retire_n;
    endtask

    task automatic check_counts();
        check_value(counts.retired, exp_cnt.retired, "retired count");
        check_value(counts.branches, exp_cnt.branches, "branch count");
        check_value(counts.taken, exp_cnt.taken, "taken count");
        check_value(counts.bp_hits, exp_cnt.bp_hits, "bp hit count");
        check_value(counts.loads, exp_cnt.loads, "load count");
        check_value(counts.stores, exp_cnt.stores, "store count");
    endtask

    initial begin
        void'($urandom(32'hae24_8db9));
        ctrl_dec_exe      = '0;
        ctrl_exe_mem      = '0;
        ctrl_mem_wbk      = '0;
        inst_dec          = '0;
        pc_dec            = '0;
        branch_resolution = B_NT;
        bp_hit            = 1'b0;
        dmem_req          = '0;
        inst_retired      = 1'b0;
        m_exe_inst        = '0;
        m_mem_inst        = '0;
        m_wbk_inst        = '0;
        m_mem_ev          = '0;
        m_wbk_ev          = '0;
        m_exe_bub         = 1'b1;
        m_mem_bub         = 1'b1;
        m_wbk_bub         = 1'b1;
        m_wbk_fresh       = 1'b0;
        retire_due        = 1'b0;
        exp_cnt           = '0;
        wait (rst_n === 1'b1);
        check_value(trace_valid, 1'b0, "trace_valid after reset");
        check_value(|counts, 1'b0, "counters after reset");
        repeat (STIM_CYCLES) begin
            step_cycle(1'b1);
            @(negedge clk);
        end
        repeat (DRAIN_CYCLES) begin
            step_cycle(1'b0);
            @(negedge clk);
        end
        ctrl_dec_exe = '0;
        ctrl_exe_mem = '0;
        ctrl_mem_wbk = '0;
        inst_retired = 1'b0;
        retire_due   = 1'b0;
        check_counts();
        check_value(counts.bubbles_seen, exp_cnt.bubbles_seen, "bubbles_seen count");
        @(negedge clk);
        check_value(exp_q.size(), 0, "records never traced");
        if (fail_cnt == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    always @(posedge clk) begin
        valid_due <= retire_due;
    end

    // outputs are stable by the falling edge
    always @(negedge clk) begin : compare_trace
        exp_item_t item;
        if (rst_n) begin
            check_value(trace_valid, valid_due, "trace_valid");
            if (trace_valid) begin
                check_value(exp_q.size() == 0, 1'b0, "trace_valid with no retirement pending");
                item = exp_q.pop_front();
                check_value(trace.inst_rec, item.rec.inst_rec, "instruction record");
                check_value(trace.exe_ev, item.rec.exe_ev, "exe event");
                check_value(trace.bubble, item.rec.bubble, "record bubble bit");
                exp_cnt_snapshot_check(item.cnt);
            end
        end
    end

    task automatic exp_cnt_snapshot_check(input trace_cnt_t snap);
        check_value(counts.retired, snap.retired, "retired count at record");
        check_value(counts.branches, snap.branches, "branch count at record");
        check_value(counts.taken, snap.taken, "taken count at record");
        check_value(counts.bp_hits, snap.bp_hits, "bp hit count at record");
        check_value(counts.loads, snap.loads, "load count at record");
        check_value(counts.stores, snap.stores, "store count at record");
    endtask

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Checks failed");
            $fatal(1, "timeout");
        end
    end

endmodule

`default_nettype wire

/* verification/trace_clk_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module trace_clk_gen (
    output logic clk,
    output logic rst_n
);

    localparam int HALF_PERIOD  = 2;
    localparam int RESET_CYCLES = 5;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // release on a falling edge, away from the sampling edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

/* verilog/core_trace_defines.svh */
`ifndef CORE_TRACE_DEFINES_SVH
`define CORE_TRACE_DEFINES_SVH

`default_nettype none

// datapath and address width
`define ARCH_WIDTH 32

// instruction word width
`define INST_WIDTH 32

// canonical nop, addi x0, x0, 0
`define NOP 32'h0000_0013

// width of every event counter
`define CNT_WIDTH 32

`default_nettype wire

`endif

/* verilog/core_trace_pkg.sv */
`include "core_trace_defines.svh"
`default_nettype none

package core_trace_pkg;

    // rv32i major opcodes, inst[6:0]
    typedef enum logic [6:0] {
        OPC7_R_TYPE = 7'b011_0011,
        OPC7_I_TYPE = 7'b001_0011,
        OPC7_LOAD   = 7'b000_0011,
        OPC7_STORE  = 7'b010_0011,
        OPC7_BRANCH = 7'b110_0011,
        OPC7_JAL    = 7'b110_1111,
        OPC7_JALR   = 7'b110_0111,
        OPC7_LUI    = 7'b011_0111,
        OPC7_AUIPC  = 7'b001_0111,
        OPC7_SYSTEM = 7'b111_0011
    } opc7_t;

    // NONE is zero so a cleared stage reads as unknown format
    typedef enum logic [2:0] {
        FMT_NONE = 3'd0,
        FMT_R    = 3'd1,
        FMT_I    = 3'd2,
        FMT_S    = 3'd3,
        FMT_B    = 3'd4,
        FMT_J    = 3'd5,
        FMT_U    = 3'd6
    } inst_fmt_t;

    // encoded as {store, size}, same as the core's dmem size view
    typedef enum logic [3:0] {
        DMEM_LB = 4'd0,
        DMEM_LH = 4'd1,
        DMEM_LW = 4'd2,
        DMEM_SB = 4'd4,
        DMEM_SH = 4'd5,
        DMEM_SW = 4'd6,
        DMEM_NA = 4'd8
    } dmem_acc_t;

    typedef enum logic {
        B_NT = 1'b0,
        B_T  = 1'b1
    } branch_res_t;

    typedef struct packed {
        logic en;
        logic bubble;
    } stage_ctrl_t;

    typedef struct packed {
        logic                   valid;
        logic [`ARCH_WIDTH-1:0] addr;
        logic                   store;
        logic [1:0]             size;
    } dmem_req_t;

    typedef struct packed {
        logic [`INST_WIDTH-1:0] inst;
        logic [`ARCH_WIDTH-1:0] pc;
        inst_fmt_t              fmt;
        logic                   flush;
    } inst_rec_t;

    typedef struct packed {
        logic                   branch;
        logic                   taken;
        logic                   bp_hit;
        dmem_acc_t              dmem_acc;
        logic [`ARCH_WIDTH-1:0] dmem_addr;
    } exe_event_t;

    typedef struct packed {
        inst_rec_t  inst_rec;
        exe_event_t exe_ev;
        logic       bubble;
    } trace_rec_t;

    typedef struct packed {
        logic [`CNT_WIDTH-1:0] retired;
        logic [`CNT_WIDTH-1:0] branches;
        logic [`CNT_WIDTH-1:0] taken;
        logic [`CNT_WIDTH-1:0] bp_hits;
        logic [`CNT_WIDTH-1:0] loads;
        logic [`CNT_WIDTH-1:0] stores;
        logic [`CNT_WIDTH-1:0] bubbles_seen;
    } trace_cnt_t;

endpackage

`default_nettype wire

/* verilog/core_trace_top.sv */
`timescale 1ns/1ns
`include "core_trace_defines.svh"
`default_nettype none

module core_trace_top
    import core_trace_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  stage_ctrl_t            ctrl_dec_exe,
    input  stage_ctrl_t            ctrl_exe_mem,
    input  stage_ctrl_t            ctrl_mem_wbk,
    input  logic [`INST_WIDTH-1:0] inst_dec,
    input  logic [`ARCH_WIDTH-1:0] pc_dec,
    input  branch_res_t            branch_resolution,
    input  logic                   bp_hit,
    input  dmem_req_t              dmem_req,
    input  logic                   inst_retired,
    output logic                   trace_valid,
    output trace_rec_t             trace,
    output trace_cnt_t             counts
);

    inst_rec_t  inst_exe;
    logic       bubble_exe;
    exe_event_t event_exe;
    inst_rec_t  inst_wbk;
    exe_event_t event_wbk;
    logic       bubble_wbk;

    exe_event_capture u_capture (
        .clk               (clk),
        .rst_n             (rst_n),
        .ctrl_dec_exe      (ctrl_dec_exe),
        .inst_dec          (inst_dec),
        .pc_dec            (pc_dec),
        .branch_resolution (branch_resolution),
        .bp_hit            (bp_hit),
        .dmem_req          (dmem_req),
        .inst_exe          (inst_exe),
        .bubble_exe        (bubble_exe),
        .event_exe         (event_exe)
    );

    stage_shadow #(.T(inst_rec_t)) u_inst_shadow (
        .clk          (clk),
        .rst_n        (rst_n),
        .ctrl_exe_mem (ctrl_exe_mem),
        .ctrl_mem_wbk (ctrl_mem_wbk),
        .payload_exe  (inst_exe),
        .bubble_exe   (bubble_exe),
        .payload_wbk  (inst_wbk),
        .bubble_wbk   (bubble_wbk)
    );

    // same controls as the inst shadow, so its bubble bit is a copy
    stage_shadow #(.T(exe_event_t)) u_event_shadow (
        .clk          (clk),
        .rst_n        (rst_n),
        .ctrl_exe_mem (ctrl_exe_mem),
        .ctrl_mem_wbk (ctrl_mem_wbk),
        .payload_exe  (event_exe),
        .bubble_exe   (bubble_exe),
        .payload_wbk  (event_wbk),
        .bubble_wbk   ()
    );

    retire_trace u_retire (
        .clk          (clk),
        .rst_n        (rst_n),
        .inst_wbk     (inst_wbk),
        .event_wbk    (event_wbk),
        .bubble_wbk   (bubble_wbk),
        .inst_retired (inst_retired),
        .trace_valid  (trace_valid),
        .trace        (trace),
        .counts       (counts)
    );

endmodule

`default_nettype wire

/* verilog/exe_event_capture.sv */
`timescale 1ns/1ns
`include "core_trace_defines.svh"
`default_nettype none

module exe_event_capture
    import core_trace_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  stage_ctrl_t            ctrl_dec_exe,
    input  logic [`INST_WIDTH-1:0] inst_dec,
    input  logic [`ARCH_WIDTH-1:0] pc_dec,
    input  branch_res_t            branch_resolution,
    input  logic                   bp_hit,
    input  dmem_req_t              dmem_req,
    output inst_rec_t              inst_exe,
    output logic                   bubble_exe,
    output exe_event_t             event_exe
);

    // opcode to format, anything unlisted is NONE
    function automatic inst_fmt_t classify(input logic [`INST_WIDTH-1:0] inst);
        inst_fmt_t fmt;
        case (inst[6:0])
            OPC7_R_TYPE: fmt = FMT_R;
            OPC7_I_TYPE,
            OPC7_LOAD,
            OPC7_JALR,
            OPC7_SYSTEM: fmt = FMT_I;
            OPC7_STORE:  fmt = FMT_S;
            OPC7_BRANCH: fmt = FMT_B;
            OPC7_JAL:    fmt = FMT_J;
            OPC7_LUI,
            OPC7_AUIPC:  fmt = FMT_U;
            default:     fmt = FMT_NONE;
        endcase
        return fmt;
    endfunction

    // dec -> exe stage register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            inst_exe   <= '0;
            bubble_exe <= 1'b1;
        end else if (ctrl_dec_exe.en) begin
            if (ctrl_dec_exe.bubble) begin
                inst_exe   <= '0;
                bubble_exe <= 1'b1;
            end else begin
                inst_exe.inst  <= inst_dec;
                inst_exe.pc    <= pc_dec;
                inst_exe.fmt   <= classify(inst_dec);
                inst_exe.flush <= (inst_dec == '0);
                bubble_exe     <= 1'b0;
            end
        end
    end

    logic      is_branch;
    dmem_acc_t acc_exe;

    assign is_branch = (inst_exe.inst[6:0] == OPC7_BRANCH);

    // dword sizes do not exist on rv32, treat them as no access
    always_comb begin
        acc_exe = DMEM_NA;
        if (dmem_req.valid) begin
            case ({dmem_req.store, dmem_req.size})
                3'b000:  acc_exe = DMEM_LB;
                3'b001:  acc_exe = DMEM_LH;
                3'b010:  acc_exe = DMEM_LW;
                3'b100:  acc_exe = DMEM_SB;
                3'b101:  acc_exe = DMEM_SH;
                3'b110:  acc_exe = DMEM_SW;
                default: acc_exe = DMEM_NA;
            endcase
        end
    end

    always_comb begin
        event_exe.branch    = is_branch;
        event_exe.taken     = is_branch && (branch_resolution == B_T);
        event_exe.bp_hit    = is_branch && bp_hit;
        event_exe.dmem_acc  = acc_exe;
        event_exe.dmem_addr = dmem_req.valid ? dmem_req.addr : '0;
    end

endmodule

`default_nettype wire

/* verilog/retire_trace.sv */
`timescale 1ns/1ns
`default_nettype none

module retire_trace
    import core_trace_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  inst_rec_t  inst_wbk,
    input  exe_event_t event_wbk,
    input  logic       bubble_wbk,
    input  logic       inst_retired,
    output logic       trace_valid,
    output trace_rec_t trace,
    output trace_cnt_t counts
);

    logic retire;
    logic is_load;
    logic is_store;

    // only a real instruction in wbk produces a record
    assign retire = inst_retired && !bubble_wbk;

    assign is_load  = event_wbk.dmem_acc inside {DMEM_LB, DMEM_LH, DMEM_LW};
    assign is_store = event_wbk.dmem_acc inside {DMEM_SB, DMEM_SH, DMEM_SW};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            trace_valid <= 1'b0;
        end else begin
            trace_valid <= retire;
        end
    end

    // record holds until the next retirement
    always_ff @(posedge clk) begin
        if (retire) begin
            trace.inst_rec <= inst_wbk;
            trace.exe_ev   <= event_wbk;
            trace.bubble   <= bubble_wbk;
        end
    end

    // per-record event counters
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            counts.retired  <= '0;
            counts.branches <= '0;
            counts.taken    <= '0;
            counts.bp_hits  <= '0;
            counts.loads    <= '0;
            counts.stores   <= '0;
        end else if (retire) begin
            counts.retired <= counts.retired + 1'b1;
            if (event_wbk.branch) begin
                counts.branches <= counts.branches + 1'b1;
            end
            if (event_wbk.taken) begin
                counts.taken <= counts.taken + 1'b1;
            end
            if (event_wbk.bp_hit) begin
                counts.bp_hits <= counts.bp_hits + 1'b1;
            end
            if (is_load) begin
                counts.loads <= counts.loads + 1'b1;
            end
            if (is_store) begin
                counts.stores <= counts.stores + 1'b1;
            end
        end
    end

    // every cycle with a bubble sitting in wbk, retired or not
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            counts.bubbles_seen <= '0;
        end else if (bubble_wbk) begin
            counts.bubbles_seen <= counts.bubbles_seen + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* verilog/stage_shadow.sv */
`timescale 1ns/1ns
`default_nettype none

module stage_shadow
    import core_trace_pkg::*;
#(
    parameter type T = inst_rec_t
) (
    input  logic        clk,
    input  logic        rst_n,
    input  stage_ctrl_t ctrl_exe_mem,
    input  stage_ctrl_t ctrl_mem_wbk,
    input  T            payload_exe,
    input  logic        bubble_exe,
    output T            payload_wbk,
    output logic        bubble_wbk
);

    T     payload_mem;
    logic bubble_mem;

    // exe -> mem
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            payload_mem <= '0;
            bubble_mem  <= 1'b1;
        end else if (ctrl_exe_mem.en) begin
            if (ctrl_exe_mem.bubble) begin
                payload_mem <= '0;
                bubble_mem  <= 1'b1;
            end else begin
                payload_mem <= payload_exe;
                // upstream bubble rides along with its payload
                bubble_mem  <= bubble_exe;
            end
        end
    end

    // mem -> wbk
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            payload_wbk <= '0;
            bubble_wbk  <= 1'b1;
        end else if (ctrl_mem_wbk.en) begin
            if (ctrl_mem_wbk.bubble) begin
                payload_wbk <= '0;
                bubble_wbk  <= 1'b1;
            end else begin
                payload_wbk <= payload_mem;
                bubble_wbk  <= bubble_mem;
            end
        end
    end

endmodule

`default_nettype wire
